// File: Bender.yml
package:
  name: fc_layer

sources:
  - verilog/fc_pkg.sv
  - verilog/fc_feature_feeder.sv
  - verilog/fc_neuron_lane.sv
  - verilog/fc_result_drain.sv
  - verilog/fc_layer_top.sv
  - target: test
    files:
      - testbench/tb_fc_layer.sv

// File: all.f
verilog/fc_pkg.sv
verilog/fc_feature_feeder.sv
verilog/fc_neuron_lane.sv
verilog/fc_result_drain.sv
verilog/fc_layer_top.sv
testbench/tb_fc_layer.sv

// File: fc_weights.mem
// word = {w_ch2, w_ch1, w_ch0}, lane 0 positions 0..15, then lane 1, then lane 2
02FE01
04FC02
06FA03
08F804
0AF605
0CF406
0EF207
10F008
12EE09
14EC0A
16EA0B
18E80C
1AE60D
1CE40E
1EE20F
20E010
FF0102
FE0204
FD0306
FC0408
FB050A
FA060C
F9070E
F80810
F70912
F60A14
F50B16
F40C18
F30D1A
F20E1C
F10F1E
F01020
0102FF
0204FE
0306FD
0408FC
050AFB
060CFA
070EF9
0810F8
0912F7
0A14F6
0B16F5
0C18F4
0D1AF3
0E1CF2
0F1EF1
1020F0

// File: testbench/fc_test_input.txt
# per frame: 16 lines of features ch0 ch1 ch2 (hex), then sums lane0 lane1 lane2
# (signed decimal), then the downstream credit delay in cycles
0100 FFC0 0020
0200 FF80 0040
0300 FF40 0060
0400 FF00 0080
0500 FEC0 00A0
0600 FE80 00C0
0700 FE40 00E0
0800 FE00 0100
0900 FDC0 0120
0A00 FD80 0140
0B00 FD40 0160
0C00 FD00 0180
0D00 FCC0 01A0
0E00 FC80 01C0
0F00 FC40 01E0
1000 FC00 0200
670208 622336 -526592
150
FE00 0080 0100
FC00 0100 0200
FA00 0180 0300
F800 0200 0400
F600 0280 0500
F400 0300 0600
F200 0380 0700
F000 0400 0800
EE00 0480 0900
EC00 0500 0A00
EA00 0580 0B00
E800 0600 0C00
E600 0680 0D00
E400 0700 0E00
E200 0780 0F00
E000 0800 1000
-382976 -1723392 1531904
90
0400 0030 FF80
0800 0060 FF00
0C00 0090 FE80
1000 00C0 FE00
1400 00F0 FD80
1800 0120 FD00
1C00 0150 FC80
2000 0180 FC00
2400 01B0 FB80
2800 01E0 FB00
2C00 0210 FA80
3000 0240 FA00
3400 0270 F980
3800 02A0 F900
3C00 02D0 F880
4000 0300 F800
1005312 3327104 -1579776
3

// File: testbench/tb_fc_layer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fc_layer;
    import fc_pkg::*;

    logic        clk;
    logic        reset_n;
    logic        i_feat_valid;
    fc_feature_t i_feat;
    logic        o_feat_credit;
    logic        i_res_credit;
    logic        o_res_valid;
    fc_result_t  o_res;

    fc_feature_t feat_q [$];    // every vector, frame after frame
    fc_result_t  exp_q [$];     // expected sums per frame
    int          delay_q [$];   // downstream credit delay per frame
    int          ret_q [$];     // cycles at which credits go back

    integer seed;
    int     feat_credits;       // upstream credits held by the source
    int     res_credits;        // mirror of the drain's credit count
    int     n_results;
    int     cycle;
    int     limit;
    int     n_res_err;
    int     n_credit_err;
    int     n_proto_err;
    bit     loaded;

    fc_layer_top u_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_feat_valid  (i_feat_valid),
        .i_feat        (i_feat),
        .o_feat_credit (o_feat_credit),
        .i_res_credit  (i_res_credit),
        .o_res_valid   (o_res_valid),
        .o_res         (o_res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_result(input string name, input fc_result_t expected,
                                input fc_result_t actual);
        if (actual !== expected) begin
            n_res_err++;
            $display("error %s: expected %0d %0d %0d actual %0d %0d %0d", name,
                     expected.sum[0], expected.sum[1], expected.sum[2],
                     actual.sum[0], actual.sum[1], actual.sum[2]);
        end
    endtask

    task automatic check_credit(input string name, input int expected, input int actual);
        if (actual != expected) begin
            n_credit_err++;
            $display("error %s: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic require_quiet_outputs(input string phase);
        if (o_feat_credit !== 1'b0 || o_res_valid !== 1'b0) begin
            n_proto_err++;
            $display("o_feat_credit or o_res_valid is not low %s", phase);
        end
    endtask

    // --------------------------------------------------
    // stimulus file and driver
    // --------------------------------------------------
    task automatic load_stimulus();
        int                 fd;
        int                 rc;
        int                 e0;
        int                 e1;
        int                 e2;
        int                 dly;
        int                 max_dly;
        bit                 more;
        logic [FEAT_BW-1:0] f0;
        logic [FEAT_BW-1:0] f1;
        logic [FEAT_BW-1:0] f2;
        logic [8*120-1:0]   line_buf;
        fc_feature_t        fv;
        fc_result_t         ev;
        max_dly = 0;
        fd = $fopen("testbench/fc_test_input.txt", "r");
        if (fd == 0) begin
            n_proto_err++;
            $display("could not open the stimulus file testbench/fc_test_input.txt");
        end else begin
            rc = $fgets(line_buf, fd);   // two column header lines
            rc = $fgets(line_buf, fd);
            more = 1'b1;
            while (more) begin
                for (int p = 0; p < N_POS && more; p++) begin
                    rc = $fscanf(fd, " %h %h %h", f0, f1, f2);
                    if (rc != 3) begin
                        more = 1'b0;
                    end else begin
                        fv.ch[0] = f0;
                        fv.ch[1] = f1;
                        fv.ch[2] = f2;
                        feat_q.push_back(fv);
                    end
                end
                if (more) begin
                    rc = $fscanf(fd, " %d %d %d", e0, e1, e2);
                    rc = rc + $fscanf(fd, " %d", dly);
                    ev.sum[0] = acc_t'(e0);
                    ev.sum[1] = acc_t'(e1);
                    ev.sum[2] = acc_t'(e2);
                    exp_q.push_back(ev);
                    delay_q.push_back(dly);
                    if (dly > max_dly) begin
                        max_dly = dly;
                    end
                end
            end
            $fclose(fd);
        end
        limit  = exp_q.size() * (N_POS * 5 + max_dly + 50) + 16;   // reset included
        loaded = 1'b1;
    endtask

    task automatic send_features();
        int idle;
        for (int i = 0; i < feat_q.size(); i++) begin
            idle = $random(seed) & 3;   // 0 to 3 idle cycles
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
            while (feat_credits == 0) begin
                @(posedge clk);
                #1;
            end
            i_feat_valid = 1'b1;
            i_feat       = feat_q[i];
            @(posedge clk);
            #1;
            i_feat_valid = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // credit models, result monitor, credit return
    // --------------------------------------------------
    always @(posedge clk) begin
        if (reset_n) begin
            if (i_feat_valid && feat_credits == 0) begin
                n_proto_err++;
                $display("source sent a feature vector while holding no credit");
            end
            if (i_feat_valid) feat_credits--;
            if (o_feat_credit) feat_credits++;
            if (feat_credits > FEAT_CREDITS) begin
                n_proto_err++;
                $display("more upstream credits returned than were spent");
            end
            if (o_res_valid) begin
                if (res_credits == 0) begin
                    n_proto_err++;
                    $display("result delivered while the drain held no credit");
                end
                if (n_results >= exp_q.size()) begin
                    n_proto_err++;
                    $display("result delivered after every frame was already answered");
                end else begin
                    check_result($sformatf("frame %0d", n_results), exp_q[n_results], o_res);
                    ret_q.push_back(cycle + delay_q[n_results]);
                end
                n_results++;
                res_credits--;
            end
            if (i_res_credit) res_credits++;
        end
        cycle++;
        #1;
        if (ret_q.size() != 0 && ret_q[0] <= cycle) begin
            i_res_credit = 1'b1;   // one credit back per cycle
            void'(ret_q.pop_front());
        end else begin
            i_res_credit = 1'b0;
        end
    end

    initial begin
        wait (loaded);
        repeat (limit) @(posedge clk);
        $display("timeout: results still missing after %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed         = 86;
        reset_n      = 1'b0;
        i_feat_valid = 1'b0;
        i_feat       = '0;
        i_res_credit = 1'b0;
        feat_credits = FEAT_CREDITS;
        res_credits  = RES_DEPTH;
        n_results    = 0;
        cycle        = 0;
        n_res_err    = 0;
        n_credit_err = 0;
        n_proto_err  = 0;
        load_stimulus();
        repeat (16) begin
            @(posedge clk);
            #1;
            require_quiet_outputs("during reset");
        end
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        require_quiet_outputs("right after reset");
        send_features();
        while (n_results < exp_q.size() || ret_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);   // last credit pulse and any stray result
        check_credit("upstream credits", FEAT_CREDITS, feat_credits);
        check_credit("downstream credits", RES_DEPTH, res_credits);
        check_credit("results delivered", exp_q.size(), n_results);
        $display("errors: %0d result, %0d credit, %0d protocol",
                 n_res_err, n_credit_err, n_proto_err);
        if (n_res_err + n_credit_err + n_proto_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/fc_feature_feeder.sv
`timescale 1ns/100ps
`default_nettype none

module fc_feature_feeder (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_feat_valid,
    input  fc_pkg::fc_feature_t i_feat,
    input  logic                i_slot_free,
    output fc_pkg::fc_issue_t   o_issue,
    output logic                o_feat_credit
);
    import fc_pkg::*;

    localparam int PTR_BW = $clog2(FEAT_CREDITS);
    localparam int CNT_BW = $clog2(FEAT_CREDITS + 1);

    fc_feature_t       buf_q [FEAT_CREDITS];
    logic [PTR_BW-1:0] wr_ptr_q;
    logic [PTR_BW-1:0] rd_ptr_q;
    logic [CNT_BW-1:0] cnt_q;
    logic [POS_BW-1:0] pos_q;     // position of the head entry
    logic              head_last;
    logic              issue_fire;

    assign head_last  = (pos_q == POS_BW'(N_POS - 1));
    // last position holds until the drain has reserved a result slot
    assign issue_fire = (cnt_q != '0) && (!head_last || i_slot_free);

    always_comb begin
        o_issue.valid = issue_fire;
        o_issue.pos   = pos_q;
        o_issue.last  = head_last;
        o_issue.feat  = buf_q[rd_ptr_q];
    end

    assign o_feat_credit = issue_fire;   // entry freed in the issue cycle

    // --------------------------------------------------
    // buffer storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_feat_valid) begin
            buf_q[wr_ptr_q] <= i_feat;   // source only sends with a credit
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (i_feat_valid) begin
                wr_ptr_q <= (wr_ptr_q == PTR_BW'(FEAT_CREDITS - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (issue_fire) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BW'(FEAT_CREDITS - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({i_feat_valid, issue_fire})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // position counter, wraps once per frame
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pos_q <= '0;
        end else if (issue_fire) begin
            pos_q <= head_last ? '0 : pos_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fc_layer_top.sv
`timescale 1ns/100ps
`default_nettype none

module fc_layer_top (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                i_feat_valid,
    input  fc_pkg::fc_feature_t i_feat,
    output logic                o_feat_credit,
    input  logic                i_res_credit,
    output logic                o_res_valid,
    output fc_pkg::fc_result_t  o_res
);
    import fc_pkg::*;

    wire fc_issue_t     issue;        // broadcast to every lane
    wire                slot_free;
    wire                last_issue;
    wire [N_NEURON-1:0] lane_done;
    wire fc_result_t    lane_sums;

    assign last_issue = issue.valid & issue.last;   // reserves a result slot

    fc_feature_feeder u_feeder (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_feat_valid  (i_feat_valid),
        .i_feat        (i_feat),
        .i_slot_free   (slot_free),
        .o_issue       (issue),
        .o_feat_credit (o_feat_credit)
    );

    // --------------------------------------------------
    // neuron lanes
    // --------------------------------------------------
    for (genvar g = 0; g < N_NEURON; g++) begin : gen_lane
        fc_neuron_lane #(
            .LANE (g)
        ) u_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .i_issue (issue),
            .o_done  (lane_done[g]),
            .o_sum   (lane_sums.sum[g])
        );
    end

    fc_result_drain u_drain (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_lane_done  (lane_done),
        .i_lane_sum   (lane_sums),
        .i_last_issue (last_issue),
        .i_res_credit (i_res_credit),
        .o_slot_free  (slot_free),
        .o_res_valid  (o_res_valid),
        .o_res        (o_res)
    );

endmodule

`default_nettype wire

// File: verilog/fc_neuron_lane.sv
`timescale 1ns/100ps
`default_nettype none

module fc_neuron_lane #(
    parameter int LANE = 0
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  fc_pkg::fc_issue_t                i_issue,
    output logic                             o_done,
    output logic signed [fc_pkg::ACC_BW-1:0] o_sum
);
    import fc_pkg::*;

    localparam int ROM_WORDS = N_NEURON * N_POS;
    localparam int ROM_BASE  = LANE * N_POS;   // first word of this neuron

    logic [N_CHAN*W_BW-1:0]    w_rom [ROM_WORDS];
    logic [N_CHAN*W_BW-1:0]    w_word;
    logic signed [W_BW-1:0]    w_chan [N_CHAN];

    logic signed [PROD_BW-1:0] prod_q [N_CHAN];
    logic                      prod_valid_q;
    logic                      prod_last_q;
    logic signed [KER_BW-1:0]  ker_sum;
    logic signed [ACC_BW-1:0]  acc_q;
    logic signed [ACC_BW-1:0]  acc_next;

    // one word per lane and position, three weights packed
    initial begin
        $readmemh("fc_weights.mem", w_rom);
    end

    assign w_word = w_rom[ROM_BASE + i_issue.pos];

    always_comb begin
        for (int c = 0; c < N_CHAN; c++) begin
            w_chan[c] = w_word[c*W_BW +: W_BW];   // channel 0 in low byte
        end
    end

    // --------------------------------------------------
    // stage 1: multiply
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid_q <= 1'b0;
            prod_last_q  <= 1'b0;
        end else begin
            prod_valid_q <= i_issue.valid;
            prod_last_q  <= i_issue.valid & i_issue.last;
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue.valid) begin
            for (int c = 0; c < N_CHAN; c++) begin
                prod_q[c] <= i_issue.feat.ch[c] * w_chan[c];
            end
        end
    end

    // --------------------------------------------------
    // stage 2: channel sum and frame accumulate
    // --------------------------------------------------
    always_comb begin
        ker_sum = '0;
        for (int c = 0; c < N_CHAN; c++) begin
            ker_sum = ker_sum + KER_BW'(prod_q[c]);   // sign extended
        end
    end

    assign acc_next = acc_q + ACC_BW'(ker_sum);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_q  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= prod_last_q;
            if (prod_valid_q) begin
                acc_q <= prod_last_q ? '0 : acc_next;   // restart per frame
            end
        end
    end

    // final sum held until the next frame completes
    always_ff @(posedge clk) begin
        if (prod_last_q) begin
            o_sum <= acc_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fc_pkg.sv
`default_nettype none

package fc_pkg;

    // --------------------------------------------------
    // layer dimensions
    // --------------------------------------------------
    localparam int N_CHAN   = 3;     // input channels per position
    localparam int N_NEURON = 3;     // one lane per output neuron
    localparam int N_POS    = 16;    // 4x4 max-pool map
    localparam int POS_BW   = 4;

    // --------------------------------------------------
    // datapath widths
    // --------------------------------------------------
    localparam int FEAT_BW = 16;
    localparam int W_BW    = 8;
    localparam int PROD_BW = FEAT_BW + W_BW;      // 24
    localparam int KER_BW  = PROD_BW + 2;         // sum of three products
    localparam int ACC_BW  = KER_BW + POS_BW;     // headroom for 16 adds

    // flow control
    localparam int FEAT_CREDITS = 2;   // same as feeder buffer depth
    localparam int RES_DEPTH    = 2;   // result queue, also initial credits

    typedef logic signed [FEAT_BW-1:0] feat_t;
    typedef logic signed [ACC_BW-1:0]  acc_t;

    // one pooled position, channel 0 in the low bits
    typedef struct packed {
        feat_t [N_CHAN-1:0] ch;
    } fc_feature_t;

    typedef struct packed {
        logic              valid;
        logic [POS_BW-1:0] pos;
        logic              last;   // final position of the frame
        fc_feature_t       feat;
    } fc_issue_t;

    typedef struct packed {
        acc_t [N_NEURON-1:0] sum;
    } fc_result_t;

endpackage

`default_nettype wire

// File: verilog/fc_result_drain.sv
`timescale 1ns/100ps
`default_nettype none

module fc_result_drain (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [fc_pkg::N_NEURON-1:0] i_lane_done,
    input  fc_pkg::fc_result_t          i_lane_sum,
    input  logic                        i_last_issue,
    input  logic                        i_res_credit,
    output logic                        o_slot_free,
    output logic                        o_res_valid,
    output fc_pkg::fc_result_t          o_res
);
    import fc_pkg::*;

    localparam int PTR_BW = $clog2(RES_DEPTH);
    localparam int CNT_BW = $clog2(RES_DEPTH + 1);

    fc_result_t        q_mem [RES_DEPTH];
    logic [PTR_BW-1:0] wr_ptr_q;
    logic [PTR_BW-1:0] rd_ptr_q;
    logic [CNT_BW-1:0] q_cnt_q;
    logic [CNT_BW-1:0] credit_q;      // downstream credits held
    logic              in_flight_q;   // last position issued, sums pending
    logic [CNT_BW:0]   occupancy;
    logic              push;
    logic              pop;

    assign push = &i_lane_done;
    assign pop  = (q_cnt_q != '0) && (credit_q != '0);

    assign occupancy   = {1'b0, q_cnt_q} + {{CNT_BW{1'b0}}, in_flight_q};
    assign o_slot_free = (occupancy < RES_DEPTH);

    assign o_res_valid = pop;
    assign o_res       = q_mem[rd_ptr_q];

    // --------------------------------------------------
    // result queue
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            q_mem[wr_ptr_q] <= i_lane_sum;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            q_cnt_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_BW'(RES_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_BW'(RES_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   q_cnt_q <= q_cnt_q + 1'b1;
                2'b01:   q_cnt_q <= q_cnt_q - 1'b1;
                default: q_cnt_q <= q_cnt_q;
            endcase
        end
    end

    // credits and slot reservation
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            credit_q    <= CNT_BW'(RES_DEPTH);
            in_flight_q <= 1'b0;
        end else begin
            case ({pop, i_res_credit})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
            if (i_last_issue) begin
                in_flight_q <= 1'b1;
            end else if (push) begin
                in_flight_q <= 1'b0;   // slot now counted in the queue
            end
        end
    end

endmodule

`default_nettype wire
